// ==== src.f ====
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/mem_port.sv
hdl/cpu_top.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
	exit 0
fi
exit 1

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int NUM_TESTS = 10;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 40;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + RUN_CYCLES + 2);
	localparam logic [15:0] RESULT_ADDR = 16'h0080;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [23:0] imem [0:65535];
	logic [7:0] dmem [0:65535];
	logic [15:0] iaddr_q;
	logic [15:0] rdata_q;
	logic [15:0] reset_fetch;
	logic [15:0] last_data;
	logic [1:0] last_lanes;
	int store_count;
	int reset_stores;
	int cycles;

	string names [NUM_TESTS];
	logic [23:0] words [NUM_TESTS][8];
	int counts [NUM_TESTS];
	logic [15:0] exp_data [NUM_TESTS];
	logic [1:0] exp_lanes [NUM_TESTS];

	cpu_top DUT (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	// instruction memory, one edge of latency
	always @(posedge clk)
		iaddr_q <= iread_addr;

	always @(negedge clk)
		iread_data <= imem[iaddr_q];

	// data memory is write-first, stores are recorded here
	always @(posedge clk)
	begin : data_mem
		logic [15:0] hi_addr;
		hi_addr = dwrite_addr + 16'd1;
		if (dwrite_en[0])
			dmem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[hi_addr] = dwrite_data[15:8];
		if (dwrite_en != 2'b00 && reset)
			reset_stores++;
		if (dwrite_en != 2'b00 && dwrite_addr == RESULT_ADDR)
		begin
			last_data = dwrite_data;
			last_lanes = dwrite_en;
			store_count++;
		end
		if (reset)
			reset_fetch = iread_addr;
		hi_addr = dread_addr + 16'd1;
		rdata_q = {dmem[hi_addr], dmem[dread_addr]};
	end

	always @(negedge clk)
		dread_data <= rdata_q;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			abort_run("timeout: the tests ran past their cycle limit");
	end

	function automatic int inst_len(input logic [7:0] op);
		case (op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			JRZ_D, JRNZ_D, JRC_D:
				return 2;
			ADD_XL_DIR, LD_DIR_XL, LDW_Y_IMMD, LDW_DIR_Y, JP_IMMD:
				return 3;
			default:
				return 1;
		endcase
	endfunction

	task automatic add_word(input int r, input logic [23:0] w);
		words[r][counts[r]] = w;
		counts[r]++;
	endtask

	task automatic set_expect(input int r, input string name, input logic [15:0] data,
		input logic [1:0] lanes);
		names[r] = name;
		exp_data[r] = data;
		exp_lanes[r] = lanes;
	endtask

	// setup, branch +8, fall-through stores aa, target stores 55
	task automatic add_branch_row(input int r, input string name, input logic [23:0] setup,
		input opcode_t br, input logic [7:0] marker);
		set_expect(r, name, {8'h00, marker}, LANES_LO);
		add_word(r, setup);
		add_word(r, {8'h00, 8'h08, br});
		add_word(r, {8'h00, 8'haa, LD_XL_IMMD});
		add_word(r, {RESULT_ADDR, LD_DIR_XL});
		add_word(r, {16'h0000, TRAP});
		add_word(r, {8'h00, 8'h55, LD_XL_IMMD});
		add_word(r, {RESULT_ADDR, LD_DIR_XL});
		add_word(r, {16'h0000, TRAP});
	endtask

	task automatic build_table();
		set_expect(0, "imm_arith", {8'h00, 8'h37 + 8'h5a - 8'h21}, LANES_LO);
		add_word(0, {8'h00, 8'h37, LD_XL_IMMD});
		add_word(0, {8'h00, 8'h5a, ADD_XL_IMMD});
		add_word(0, {8'h00, 8'h21, SUB_XL_IMMD});
		add_word(0, {RESULT_ADDR, LD_DIR_XL});
		add_word(0, {16'h0000, TRAP});
		// store behind the trap is in execute when reset rises
		add_word(0, {RESULT_ADDR, LD_DIR_XL});
		// f0 + 20 carries, so jrc skips the ee load
		set_expect(1, "carry_jrc", {8'h00, 8'hf0 + 8'h20}, LANES_LO);
		add_word(1, {8'h00, 8'hf0, LD_XL_IMMD});
		add_word(1, {8'h00, 8'h20, ADD_XL_IMMD});
		add_word(1, {8'h00, 8'h04, JRC_D});
		add_word(1, {8'h00, 8'hee, LD_XL_IMMD});
		add_word(1, {RESULT_ADDR, LD_DIR_XL});
		add_word(1, {16'h0000, TRAP});
		set_expect(2, "logic", {8'h00, ((8'hc3 & 8'h0f) | 8'ha0) ^ 8'hff}, LANES_LO);
		add_word(2, {8'h00, 8'hc3, LD_XL_IMMD});
		add_word(2, {8'h00, 8'h0f, AND_XL_IMMD});
		add_word(2, {8'h00, 8'ha0, OR_XL_IMMD});
		add_word(2, {8'h00, 8'hff, XOR_XL_IMMD});
		add_word(2, {RESULT_ADDR, LD_DIR_XL});
		add_word(2, {16'h0000, TRAP});
		// xl reloaded between the store to 0090 and its read back
		set_expect(3, "direct_read", {8'h00, 8'h13 + 8'h25}, LANES_LO);
		add_word(3, {8'h00, 8'h25, LD_XL_IMMD});
		add_word(3, {16'h0090, LD_DIR_XL});
		add_word(3, {8'h00, 8'h13, LD_XL_IMMD});
		add_word(3, {16'h0090, ADD_XL_DIR});
		add_word(3, {RESULT_ADDR, LD_DIR_XL});
		add_word(3, {16'h0000, TRAP});
		set_expect(4, "word_path", 16'h1234 + 16'd2, LANES_WORD);
		add_word(4, {16'h1234, LDW_Y_IMMD});
		add_word(4, {16'h0000, INCW_Y});
		add_word(4, {16'h0000, INCW_Y});
		add_word(4, {RESULT_ADDR, LDW_DIR_Y});
		add_word(4, {16'h0000, TRAP});
		add_branch_row(5, "jrz_taken", {8'h00, 8'h00, SUB_XL_IMMD}, JRZ_D, 8'h55);
		add_branch_row(6, "jrz_not_taken", {8'h00, 8'h01, ADD_XL_IMMD}, JRZ_D, 8'haa);
		add_branch_row(7, "jrnz_taken", {8'h00, 8'h01, ADD_XL_IMMD}, JRNZ_D, 8'h55);
		add_branch_row(8, "jrnz_not_taken", {8'h00, 8'h00, SUB_XL_IMMD}, JRNZ_D, 8'haa);
		set_expect(9, "jp_abs", {8'h00, 8'h66}, LANES_LO);
		add_word(9, {16'h4009, JP_IMMD});
		add_word(9, {8'h00, 8'haa, LD_XL_IMMD});
		add_word(9, {RESULT_ADDR, LD_DIR_XL});
		add_word(9, {16'h0000, TRAP});
		add_word(9, {8'h00, 8'h66, LD_XL_IMMD});
		add_word(9, {RESULT_ADDR, LD_DIR_XL});
		add_word(9, {16'h0000, TRAP});
	endtask

	task automatic run_test(input int r);
		int addr;
		int k;
		int waited;
		logic [15:0] mask;
		reset = 1'b1;
		store_count = 0;
		reset_stores = 0;
		for (addr = 0; addr < 65536; addr++)
		begin
			imem[addr] = {addr[15:0], TRAP};
			dmem[addr] = addr[15:8] ^ addr[7:0] ^ 8'h5a;
		end
		addr = RESET_VECTOR;
		for (k = 0; k < counts[r]; k++)
		begin
			imem[addr[15:0]] = words[r][k];
			addr += inst_len(words[r][k][7:0]);
		end
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		waited = 0;
		while (!trap && waited < RUN_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		mask = {{8{exp_lanes[r][1]}}, {8{exp_lanes[r][0]}}};
		assert (trap)
		else
			abort_run($sformatf("test %s: trap never rose", names[r]));
		assert (reset_stores == 0)
		else
			abort_run($sformatf("test %s: a store happened during reset", names[r]));
		assert (reset_fetch == RESET_VECTOR)
		else
			abort_run($sformatf("[FAIL] %s fetch: expected %h, actual %h",
				names[r], RESET_VECTOR, reset_fetch));
		assert (store_count == 1)
		else
			abort_run($sformatf("test %s: expected one result store, saw %0d",
				names[r], store_count));
		assert (last_lanes == exp_lanes[r])
		else
			abort_run($sformatf("[FAIL] %s lanes: expected %b, actual %b",
				names[r], exp_lanes[r], last_lanes));
		assert ((last_data & mask) == exp_data[r])
		else
			abort_run($sformatf("[FAIL] %s data: expected %h, actual %h",
				names[r], exp_data[r], last_data & mask));
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		iaddr_q = RESET_VECTOR;
		rdata_q = '0;
		reset_fetch = '0;
		last_data = '0;
		last_lanes = '0;
		cycles = 0;
		for (int r = 0; r < NUM_TESTS; r++)
			counts[r] = 0;
		build_table();
		for (int r = 0; r < NUM_TESTS; r++)
			run_test(r);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/cpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_chk import cpu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [WORD_W-1:0] iread_addr,
	input wire [1:0] dwrite_en
);

	assert property (@(posedge clk) reset |-> dwrite_en == 2'b00)
	else
		$error("store enable active during reset");

	assert property (@(posedge clk) reset |-> iread_addr == RESET_VECTOR)
	else
		$error("fetch address is not the reset vector during reset");

	// a word store always includes the low byte
	assert property (@(posedge clk) dwrite_en != 2'b10)
	else
		$error("store enable has only the high lane set");

endmodule

bind cpu_top cpu_chk u_cpu_chk (
	.clk(clk),
	.reset(reset),
	.iread_addr(iread_addr),
	.dwrite_en(dwrite_en)
);

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input wire clk,
	input wire reset,
	output logic [WORD_W-1:0] iread_addr,
	input wire [INST_W-1:0] iread_data,
	output logic [WORD_W-1:0] dread_addr,
	input wire [WORD_W-1:0] dread_data,
	output logic [WORD_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);

	logic [INST_W-1:0] inst;
	fetch_ctrl_t fetch_ctrl;
	exec_ctrl_t exec_ctrl;
	logic [WORD_W-1:0] x;
	logic [WORD_W-1:0] y;
	logic [WORD_W-1:0] result;
	flags_t next_flags;

	// execute stage instruction register
	always_ff @(posedge clk)
	begin
		if (reset)
			inst <= {16'h0000, NOP};
		else
			inst <= iread_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			trap <= 1'b0;
		else
			trap <= exec_ctrl.trap;
	end

	decoder u_decoder (
		.next_inst(iread_data),
		.inst(inst),
		.fetch_ctrl(fetch_ctrl),
		.exec_ctrl(exec_ctrl)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.reg_sel(exec_ctrl.reg_sel),
		.reg_lanes(exec_ctrl.reg_lanes),
		.wdata(result),
		.x(x),
		.y(y)
	);

	alu u_alu (
		.clk(clk),
		.reset(reset),
		.exec_ctrl(exec_ctrl),
		.x(x),
		.y(y),
		.imm(inst[23:8]),
		.rdata(dread_data),
		.result(result),
		.next_flags(next_flags)
	);

	pc_unit u_pc_unit (
		.clk(clk),
		.reset(reset),
		.fetch_ctrl(fetch_ctrl),
		.next_inst(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr)
	);

	mem_port u_mem_port (
		.reset(reset),
		.fetch_ctrl(fetch_ctrl),
		.next_inst(iread_data),
		.exec_ctrl(exec_ctrl),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_addr(dread_addr),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port import cpu_pkg::*; (
	input wire reset,
	input wire fetch_ctrl_t fetch_ctrl,
	input wire [INST_W-1:0] next_inst,
	input wire exec_ctrl_t exec_ctrl,
	input wire [INST_W-1:0] inst,
	input wire [WORD_W-1:0] x,
	input wire [WORD_W-1:0] y,
	output logic [WORD_W-1:0] dread_addr,
	output logic [WORD_W-1:0] dwrite_addr,
	output logic [WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en
);

	// read issued in decode, data back in execute
	assign dread_addr = fetch_ctrl.dir_read ? next_inst[23:8] : '0;

	assign dwrite_addr = inst[23:8];

	// word store carries Y, byte store carries XL
	always_comb
	begin
		if (exec_ctrl.mem_lanes == LANES_WORD)
			dwrite_data = y;
		else
			dwrite_data = {8'h00, x[7:0]};
	end

	assign dwrite_en = reset ? 2'b00 : exec_ctrl.mem_lanes;

endmodule

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit import cpu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire fetch_ctrl_t fetch_ctrl,
	input wire [INST_W-1:0] next_inst,
	input wire flags_t next_flags,
	output logic [WORD_W-1:0] iread_addr
);

	// pc is the address of the instruction in decode
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] seq_addr;
	logic [WORD_W-1:0] rel_addr;
	logic [WORD_W-1:0] next_addr;
	logic [7:0] disp;
	logic taken;

	assign disp = next_inst[15:8];
	assign seq_addr = pc + WORD_W'(fetch_ctrl.len);
	assign rel_addr = pc + {{8{disp[7]}}, disp};

	// flags forwarded from the execute stage
	always_comb
	begin
		case (fetch_ctrl.branch)
			ZSET: taken = next_flags.z;
			ZCLR: taken = !next_flags.z;
			CSET: taken = next_flags.c;
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (fetch_ctrl.branch == ABS)
			next_addr = next_inst[23:8];
		else if (taken)
			next_addr = rel_addr;
		else
			next_addr = seq_addr;
	end

	assign iread_addr = reset ? RESET_VECTOR : next_addr;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_VECTOR;
		else
			pc <= next_addr;
	end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire exec_ctrl_t exec_ctrl,
	input wire [WORD_W-1:0] x,
	input wire [WORD_W-1:0] y,
	input wire [WORD_W-1:0] imm,
	input wire [WORD_W-1:0] rdata,
	output logic [WORD_W-1:0] result,
	output flags_t next_flags
);

	logic [WORD_W-1:0] b;
	logic [7:0] a8;
	logic [7:0] b8;
	logic [8:0] sum8;
	logic word_op;
	flags_t res_flags;
	flags_t flags;

	assign b = exec_ctrl.src_mem ? rdata : imm;
	assign a8 = x[7:0];
	assign b8 = b[7:0];
	assign word_op = (exec_ctrl.alu_op == PASSW) || (exec_ctrl.alu_op == INCW);

	always_comb
	begin
		sum8 = '0;
		case (exec_ctrl.alu_op)
			ADD:
				sum8 = {1'b0, a8} + {1'b0, b8};
			// carry out set means no borrow
			SUB:
				sum8 = {1'b0, a8} + {1'b0, ~b8} + 9'd1;
			default:
				sum8 = '0;
		endcase

		case (exec_ctrl.alu_op)
			PASS8:
				result = {8'h00, b8};
			ADD, SUB:
				result = {8'h00, sum8[7:0]};
			AND:
				result = {8'h00, a8 & b8};
			OR:
				result = {8'h00, a8 | b8};
			XOR:
				result = {8'h00, a8 ^ b8};
			PASSW:
				result = b;
			INCW:
				result = y + 16'd1;
			default:
				result = '0;
		endcase
	end

	always_comb
	begin
		res_flags.c = sum8[8];
		if (word_op)
		begin
			res_flags.z = (result == '0);
			res_flags.n = result[15];
		end
		else
		begin
			res_flags.z = (result[7:0] == 8'h00);
			res_flags.n = result[7];
		end
	end

	// only selected bits change
	assign next_flags.c = exec_ctrl.flag_upd.c ? res_flags.c : flags.c;
	assign next_flags.z = exec_ctrl.flag_upd.z ? res_flags.z : flags.z;
	assign next_flags.n = exec_ctrl.flag_upd.n ? res_flags.n : flags.n;

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire reg_sel,
	input wire [1:0] reg_lanes,
	input wire [WORD_W-1:0] wdata,
	output logic [WORD_W-1:0] x,
	output logic [WORD_W-1:0] y
);

	logic [WORD_W-1:0] regs [2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regs[REG_X] <= '0;
			regs[REG_Y] <= '0;
		end
		else
		begin
			// low and high bytes written independently
			if (reg_lanes[0])
				regs[reg_sel][7:0] <= wdata[7:0];
			if (reg_lanes[1])
				regs[reg_sel][15:8] <= wdata[15:8];
		end
	end

	assign x = regs[REG_X];
	assign y = regs[REG_Y];

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
	input wire [INST_W-1:0] next_inst,
	input wire [INST_W-1:0] inst,
	output fetch_ctrl_t fetch_ctrl,
	output exec_ctrl_t exec_ctrl
);

	opcode_t next_op;
	opcode_t op;

	assign next_op = opcode_t'(next_inst[7:0]);
	assign op = opcode_t'(inst[7:0]);

	// decode stage: length, branch kind, read request
	always_comb
	begin
		fetch_ctrl.len = 2'd1;
		fetch_ctrl.branch = NONE;
		fetch_ctrl.dir_read = 1'b0;
		case (next_op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD,
			AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
				fetch_ctrl.len = 2'd2;
			ADD_XL_DIR:
			begin
				fetch_ctrl.len = 2'd3;
				fetch_ctrl.dir_read = 1'b1;
			end
			LD_DIR_XL, LDW_Y_IMMD, LDW_DIR_Y:
				fetch_ctrl.len = 2'd3;
			JP_IMMD:
			begin
				fetch_ctrl.len = 2'd3;
				fetch_ctrl.branch = ABS;
			end
			JRZ_D:
			begin
				fetch_ctrl.len = 2'd2;
				fetch_ctrl.branch = ZSET;
			end
			JRNZ_D:
			begin
				fetch_ctrl.len = 2'd2;
				fetch_ctrl.branch = ZCLR;
			end
			JRC_D:
			begin
				fetch_ctrl.len = 2'd2;
				fetch_ctrl.branch = CSET;
			end
			default:
				fetch_ctrl.len = 2'd1;
		endcase
	end

	// execute stage
	always_comb
	begin
		exec_ctrl = '0;
		exec_ctrl.alu_op = PASS8;
		exec_ctrl.reg_sel = REG_X;
		case (op)
			LD_XL_IMMD:
				exec_ctrl.reg_lanes = LANES_LO;
			ADD_XL_IMMD, SUB_XL_IMMD, ADD_XL_DIR:
			begin
				exec_ctrl.alu_op = (op == SUB_XL_IMMD) ? SUB : ADD;
				exec_ctrl.src_mem = (op == ADD_XL_DIR);
				exec_ctrl.reg_lanes = LANES_LO;
				exec_ctrl.flag_upd = '{c: 1'b1, z: 1'b1, n: 1'b1};
			end
			AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
			begin
				exec_ctrl.alu_op = (op == AND_XL_IMMD) ? AND :
					(op == OR_XL_IMMD) ? OR : XOR;
				exec_ctrl.reg_lanes = LANES_LO;
				exec_ctrl.flag_upd = '{c: 1'b0, z: 1'b1, n: 1'b1};
			end
			LD_DIR_XL:
				exec_ctrl.mem_lanes = LANES_LO;
			LDW_Y_IMMD:
			begin
				exec_ctrl.alu_op = PASSW;
				exec_ctrl.reg_sel = REG_Y;
				exec_ctrl.reg_lanes = LANES_WORD;
			end
			INCW_Y:
			begin
				exec_ctrl.alu_op = INCW;
				exec_ctrl.reg_sel = REG_Y;
				exec_ctrl.reg_lanes = LANES_WORD;
				exec_ctrl.flag_upd = '{c: 1'b0, z: 1'b1, n: 1'b1};
			end
			LDW_DIR_Y:
				exec_ctrl.mem_lanes = LANES_WORD;
			TRAP:
				exec_ctrl.trap = 1'b1;
			// jumps finish in decode, unknown bytes act as nop
			default:
				exec_ctrl.alu_op = PASS8;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int INST_W = 24;

	localparam logic [WORD_W-1:0] RESET_VECTOR = 16'h4000;

	// register select and byte-lane codes
	localparam logic REG_X = 1'b0;
	localparam logic REG_Y = 1'b1;
	localparam logic [1:0] LANES_LO = 2'b01;
	localparam logic [1:0] LANES_WORD = 2'b11;

	// opcode in inst[7:0], operands in inst[23:8]
	typedef enum logic [7:0] {
		NOP         = 8'h00,
		LD_XL_IMMD  = 8'h10,
		ADD_XL_IMMD = 8'h11,
		SUB_XL_IMMD = 8'h12,
		AND_XL_IMMD = 8'h13,
		OR_XL_IMMD  = 8'h14,
		XOR_XL_IMMD = 8'h15,
		ADD_XL_DIR  = 8'h21,
		LD_DIR_XL   = 8'h30,
		LDW_Y_IMMD  = 8'h40,
		INCW_Y      = 8'h41,
		LDW_DIR_Y   = 8'h50,
		JP_IMMD     = 8'h60,
		JRZ_D       = 8'h70,
		JRNZ_D      = 8'h71,
		JRC_D       = 8'h72,
		TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		PASS8 = 4'd0,
		ADD   = 4'd1,
		SUB   = 4'd2,
		AND   = 4'd3,
		OR    = 4'd4,
		XOR   = 4'd5,
		PASSW = 4'd6,
		INCW  = 4'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		NONE = 3'd0,
		ABS  = 3'd1,
		ZSET = 3'd2,
		ZCLR = 3'd3,
		CSET = 3'd4
	} branch_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	typedef struct packed {
		logic [1:0] len;
		branch_t branch;
		logic dir_read;
	} fetch_ctrl_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic src_mem;
		logic reg_sel;
		logic [1:0] reg_lanes;
		flags_t flag_upd;
		logic [1:0] mem_lanes;
		logic trap;
	} exec_ctrl_t;

endpackage

`default_nettype wire
